// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = exu_tb
FILELIST = exu.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: exu.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_csr.sv
rtl/exu_perf_counters.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
verification/exu_tb.sv

// File: rtl/exu_alu.sv
`default_nettype none

`include "exu_defs.svh"

module exu_alu (
  input  wire logic [`EXU_XLEN-1:0] a_i,
  input  wire logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e          op_i,
  output logic [`EXU_XLEN-1:0]      res_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      exu_pkg::ALU_ADD:  res_o = a_i + b_i;
      exu_pkg::ALU_SUB:  res_o = a_i - b_i;
      exu_pkg::ALU_AND:  res_o = a_i & b_i;
      exu_pkg::ALU_OR:   res_o = a_i | b_i;
      exu_pkg::ALU_XOR:  res_o = a_i ^ b_i;
      exu_pkg::ALU_SLL:  res_o = a_i << shamt;
      exu_pkg::ALU_SRL:  res_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      exu_pkg::ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      exu_pkg::ALU_SLT: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
      end
      exu_pkg::ALU_SLTU: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
      end
      default: res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/exu_branch.sv
`default_nettype none

`include "exu_defs.svh"

module exu_branch (
  input  exu_pkg::opcode_e          opcode_i,
  input  exu_pkg::br_cond_e         br_cond_i,
  input  exu_pkg::sys_op_e          sys_op_i,
  input  wire logic [`EXU_XLEN-1:0] op1_i,
  input  wire logic [`EXU_XLEN-1:0] op2_i,
  input  wire logic [`EXU_XLEN-1:0] imm_i,
  input  wire logic [`EXU_XLEN-1:0] pc_i,
  input  wire logic [`EXU_XLEN-1:0] mtvec_i,
  input  wire logic [`EXU_XLEN-1:0] mepc_i,
  output logic                      redirect_o,
  output logic [`EXU_XLEN-1:0]      npc_o,
  output logic                      ebreak_o
);

  logic                 taken;
  logic [`EXU_XLEN-1:0] jalr_tgt;

  always_comb begin
    case (br_cond_i)
      exu_pkg::BR_EQ:  taken = op1_i == op2_i;
      exu_pkg::BR_NE:  taken = op1_i != op2_i;
      exu_pkg::BR_LT:  taken = $signed(op1_i) < $signed(op2_i);
      exu_pkg::BR_GE:  taken = $signed(op1_i) >= $signed(op2_i);
      exu_pkg::BR_LTU: taken = op1_i < op2_i;
      exu_pkg::BR_GEU: taken = op1_i >= op2_i;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_tgt = (op1_i + imm_i) & ~`EXU_XLEN'(1);

  always_comb begin
    redirect_o = 1'b0;
    npc_o      = pc_i + `EXU_XLEN'(4);
    ebreak_o   = 1'b0;
    case (opcode_i)
      exu_pkg::OP_BRANCH: begin
        redirect_o = taken;
        if (taken) npc_o = pc_i + imm_i;
      end
      exu_pkg::OP_JAL: begin
        redirect_o = 1'b1;
        npc_o      = pc_i + imm_i;
      end
      exu_pkg::OP_JALR: begin
        redirect_o = 1'b1;
        npc_o      = jalr_tgt;
      end
      exu_pkg::OP_SYSTEM: begin
        // ebreak only flags, the pc moves on
        if (sys_op_i == exu_pkg::SYS_ECALL) begin
          redirect_o = 1'b1;
          npc_o      = mtvec_i;
        end else if (sys_op_i == exu_pkg::SYS_MRET) begin
          redirect_o = 1'b1;
          npc_o      = mepc_i;
        end else if (sys_op_i == exu_pkg::SYS_EBREAK) begin
          ebreak_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/exu_csr.sv
`default_nettype none

`include "exu_defs.svh"

module exu_csr (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 retire_i,
  input  exu_pkg::opcode_e          opcode_i,
  input  exu_pkg::sys_op_e          sys_op_i,
  input  wire logic [11:0]          csr_addr_i,
  input  wire logic [`EXU_XLEN-1:0] wsrc_i,
  input  wire logic [`EXU_XLEN-1:0] pc_i,
  input  wire logic [`EXU_XLEN-1:0] mcycle_i,
  input  wire logic [`EXU_XLEN-1:0] minstret_i,
  output logic [`EXU_XLEN-1:0]      rdata_o,
  output logic [`EXU_XLEN-1:0]      mtvec_o,
  output logic [`EXU_XLEN-1:0]      mepc_o
);

  logic [`EXU_XLEN-1:0] mstatus;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mcause;
  logic [`EXU_XLEN-1:0] wval;
  logic                 is_sys;
  logic                 csr_we;

  // old value, also what rd receives
  always_comb begin
    case (csr_addr_i)
      `EXU_CSR_MSTATUS:  rdata_o = mstatus;
      `EXU_CSR_MTVEC:    rdata_o = mtvec;
      `EXU_CSR_MEPC:     rdata_o = mepc;
      `EXU_CSR_MCAUSE:   rdata_o = mcause;
      `EXU_CSR_MCYCLE:   rdata_o = mcycle_i;
      `EXU_CSR_MINSTRET: rdata_o = minstret_i;
      default:           rdata_o = '0;
    endcase
  end

  always_comb begin
    case (sys_op_i)
      exu_pkg::SYS_CSRRS: wval = rdata_o | wsrc_i;
      exu_pkg::SYS_CSRRC: wval = rdata_o & ~wsrc_i;
      default:            wval = wsrc_i;
    endcase
  end

  assign is_sys = retire_i && (opcode_i == exu_pkg::OP_SYSTEM);
  assign csr_we = is_sys && (sys_op_i == exu_pkg::SYS_CSRRW ||
                             sys_op_i == exu_pkg::SYS_CSRRS ||
                             sys_op_i == exu_pkg::SYS_CSRRC);

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= `EXU_MTVEC_RESET;
      mepc    <= '0;
      mcause  <= '0;
    end else if (csr_we) begin
      // counters and unknown addresses drop the write
      case (csr_addr_i)
        `EXU_CSR_MSTATUS: mstatus <= wval;
        `EXU_CSR_MTVEC:   mtvec   <= wval;
        `EXU_CSR_MEPC:    mepc    <= wval;
        `EXU_CSR_MCAUSE:  mcause  <= wval;
        default: ;
      endcase
    end else if (is_sys && sys_op_i == exu_pkg::SYS_ECALL) begin
      mepc   <= pc_i;
      mcause <= `EXU_CAUSE_ECALL_M;
    end else if (is_sys && sys_op_i == exu_pkg::SYS_MRET) begin
      mstatus[7] <= 1'b1;
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

// File: rtl/exu_ctrl.sv
`default_nettype none

module exu_ctrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic prev_valid_i,
  input  wire logic next_ready_i,
  input  wire logic is_mem_i,
  input  wire logic lsu_done_i,
  output logic      ready_o,
  output logic      valid_o,
  output logic      accept_o,
  output logic      retire_o,
  output logic      lsu_req_o
);

  exu_pkg::exu_state_e state;
  exu_pkg::exu_state_e state_nxt;
  exu_pkg::exu_state_e accept_tgt;

  // result slot frees up on the delivery cycle
  assign ready_o   = (state == exu_pkg::ST_IDLE) ||
                     (state == exu_pkg::ST_DONE && next_ready_i);
  assign accept_o  = prev_valid_i && ready_o;
  assign valid_o   = state == exu_pkg::ST_DONE;
  assign retire_o  = valid_o && next_ready_i;
  assign lsu_req_o = state == exu_pkg::ST_MEM;

  // where a newly accepted op goes
  assign accept_tgt = is_mem_i ? exu_pkg::ST_MEM : exu_pkg::ST_DONE;

  always_comb begin
    state_nxt = state;
    case (state)
      exu_pkg::ST_IDLE: begin
        if (accept_o) begin
          state_nxt = accept_tgt;
        end
      end
      exu_pkg::ST_MEM: begin
        // response strobe ends the request
        if (lsu_done_i) begin
          state_nxt = exu_pkg::ST_DONE;
        end
      end
      exu_pkg::ST_DONE: begin
        if (retire_o) begin
          if (accept_o) begin
            state_nxt = accept_tgt;
          end else begin
            state_nxt = exu_pkg::ST_IDLE;
          end
        end
      end
      default: state_nxt = exu_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= exu_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// datapath width
`define EXU_XLEN 32

// machine-mode CSR addresses
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

// read-only counters
`define EXU_CSR_MCYCLE   12'hB00
`define EXU_CSR_MINSTRET 12'hB02

// environment call from M-mode
`define EXU_CAUSE_ECALL_M 32'd11

`define EXU_MTVEC_RESET 32'h0000_0100

`endif

// File: rtl/exu_perf_counters.sv
`default_nettype none

`include "exu_defs.svh"

module exu_perf_counters (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            retire_i,
  output logic [`EXU_XLEN-1:0] mcycle_o,
  output logic [`EXU_XLEN-1:0] minstret_o
);

  logic [`EXU_XLEN-1:0] mcycle_q;
  logic [`EXU_XLEN-1:0] minstret_q;

  // free running cycle count
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + `EXU_XLEN'(1);
    end
  end

  // one per delivered result
  always_ff @(posedge clk) begin
    if (rst) begin
      minstret_q <= '0;
    end else if (retire_i) begin
      minstret_q <= minstret_q + `EXU_XLEN'(1);
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

`default_nettype wire

// File: rtl/exu_pkg.sv
`default_nettype none

package exu_pkg;

  // instruction class from the decoder
  typedef enum logic [2:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_SYSTEM
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  // immediate CSR forms map onto the register forms
  typedef enum logic [2:0] {
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET
  } sys_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM,
    ST_DONE
  } exu_state_e;

endpackage

`default_nettype wire

// File: rtl/exu_top.sv
`default_nettype none

`include "exu_defs.svh"

module exu_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 prev_valid_i,
  output logic                      ready_o,
  input  exu_pkg::opcode_e          opcode_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::br_cond_e         br_cond_i,
  input  exu_pkg::sys_op_e          sys_op_i,
  input  wire logic [11:0]          csr_addr_i,
  input  wire logic [`EXU_XLEN-1:0] op1_i,
  input  wire logic [`EXU_XLEN-1:0] op2_i,
  input  wire logic [`EXU_XLEN-1:0] imm_i,
  input  wire logic [`EXU_XLEN-1:0] pc_i,
  input  wire logic [4:0]           rd_i,
  output logic                      valid_o,
  input  wire logic                 next_ready_i,
  output logic [4:0]                rd_o,
  output logic                      rd_wen_o,
  output logic [`EXU_XLEN-1:0]      reg_wdata_o,
  output logic                      redirect_o,
  output logic [`EXU_XLEN-1:0]      npc_o,
  output logic                      ebreak_o,
  output logic                      lsu_req_o,
  output logic                      lsu_we_o,
  output logic [`EXU_XLEN-1:0]      lsu_addr_o,
  output logic [`EXU_XLEN-1:0]      lsu_wdata_o,
  input  wire logic                 lsu_rvalid_i,
  input  wire logic [`EXU_XLEN-1:0] lsu_rdata_i,
  input  wire logic                 lsu_wready_i
);

  exu_pkg::opcode_e     opcode_q;
  exu_pkg::alu_op_e     alu_op_q;
  exu_pkg::br_cond_e    br_cond_q;
  exu_pkg::sys_op_e     sys_op_q;
  logic [11:0]          csr_addr_q;
  logic [`EXU_XLEN-1:0] op1_q, op2_q, imm_q, pc_q, mem_rdata_q;
  logic [`EXU_XLEN-1:0] alu_res, csr_rdata, mtvec, mepc, mcycle, minstret;
  logic                 accept, retire, is_mem, lsu_done, is_csr;

  assign is_mem   = opcode_i == exu_pkg::OP_LOAD || opcode_i == exu_pkg::OP_STORE;
  assign lsu_done = lsu_we_o ? lsu_wready_i : lsu_rvalid_i;

  // opcode resets so redirect and ebreak start low
  always_ff @(posedge clk) begin
    if (rst) opcode_q <= exu_pkg::OP_ALU;
    else if (accept) opcode_q <= opcode_i;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      alu_op_q   <= alu_op_i;
      br_cond_q  <= br_cond_i;
      sys_op_q   <= sys_op_i;
      csr_addr_q <= csr_addr_i;
      op1_q      <= op1_i;
      op2_q      <= op2_i;
      imm_q      <= imm_i;
      pc_q       <= pc_i;
      rd_o       <= rd_i;
    end
    if (lsu_req_o && lsu_rvalid_i) mem_rdata_q <= lsu_rdata_i;
  end

  assign lsu_we_o    = opcode_q == exu_pkg::OP_STORE;
  assign lsu_addr_o  = op1_q + imm_q;
  assign lsu_wdata_o = op2_q;
  assign is_csr      = opcode_q == exu_pkg::OP_SYSTEM && (sys_op_q == exu_pkg::SYS_CSRRW ||
                       sys_op_q == exu_pkg::SYS_CSRRS || sys_op_q == exu_pkg::SYS_CSRRC);

  always_comb begin
    case (opcode_q)
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: reg_wdata_o = pc_q + `EXU_XLEN'(4);
      exu_pkg::OP_SYSTEM:                reg_wdata_o = csr_rdata;
      exu_pkg::OP_LOAD:                  reg_wdata_o = mem_rdata_q;
      default:                           reg_wdata_o = alu_res;
    endcase
    rd_wen_o = opcode_q == exu_pkg::OP_ALU || opcode_q == exu_pkg::OP_JAL ||
               opcode_q == exu_pkg::OP_JALR || opcode_q == exu_pkg::OP_LOAD || is_csr;
  end

  exu_ctrl u_ctrl (.clk(clk), .rst(rst), .prev_valid_i(prev_valid_i),
    .next_ready_i(next_ready_i), .is_mem_i(is_mem), .lsu_done_i(lsu_done),
    .ready_o(ready_o), .valid_o(valid_o), .accept_o(accept), .retire_o(retire),
    .lsu_req_o(lsu_req_o));

  exu_alu u_alu (.a_i(op1_q), .b_i(op2_q), .op_i(alu_op_q), .res_o(alu_res));

  exu_branch u_branch (.opcode_i(opcode_q), .br_cond_i(br_cond_q), .sys_op_i(sys_op_q),
    .op1_i(op1_q), .op2_i(op2_q), .imm_i(imm_q), .pc_i(pc_q), .mtvec_i(mtvec),
    .mepc_i(mepc), .redirect_o(redirect_o), .npc_o(npc_o), .ebreak_o(ebreak_o));

  exu_csr u_csr (.clk(clk), .rst(rst), .retire_i(retire), .opcode_i(opcode_q),
    .sys_op_i(sys_op_q), .csr_addr_i(csr_addr_q), .wsrc_i(op1_q), .pc_i(pc_q),
    .mcycle_i(mcycle), .minstret_i(minstret), .rdata_o(csr_rdata), .mtvec_o(mtvec),
    .mepc_o(mepc));

  exu_perf_counters u_perf (.clk(clk), .rst(rst), .retire_i(retire), .mcycle_o(mcycle),
    .minstret_o(minstret));

endmodule

`default_nettype wire

// File: verification/exu_tb.sv
`default_nettype none

`include "exu_defs.svh"

module exu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    exu_pkg::opcode_e     opcode;
    exu_pkg::alu_op_e     alu_op;
    exu_pkg::br_cond_e    br_cond;
    exu_pkg::sys_op_e     sys_op;
    logic [11:0]          csr_addr;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] imm;
    logic [`EXU_XLEN-1:0] pc;
    logic [4:0]           rd;
  } op_t;

  typedef struct packed {
    logic                 wen;
    logic                 redirect;
    logic                 ebreak;
    logic [`EXU_XLEN-1:0] wdata;
    logic [`EXU_XLEN-1:0] npc;
  } exp_t;

  logic                 clk;
  logic                 rst;
  logic                 prev_valid_i;
  logic                 ready_o;
  exu_pkg::opcode_e     opcode_i;
  exu_pkg::alu_op_e     alu_op_i;
  exu_pkg::br_cond_e    br_cond_i;
  exu_pkg::sys_op_e     sys_op_i;
  logic [11:0]          csr_addr_i;
  logic [`EXU_XLEN-1:0] op1_i;
  logic [`EXU_XLEN-1:0] op2_i;
  logic [`EXU_XLEN-1:0] imm_i;
  logic [`EXU_XLEN-1:0] pc_i;
  logic [4:0]           rd_i;
  logic                 valid_o;
  logic                 next_ready_i;
  logic [4:0]           rd_o;
  logic                 rd_wen_o;
  logic [`EXU_XLEN-1:0] reg_wdata_o;
  logic                 redirect_o;
  logic [`EXU_XLEN-1:0] npc_o;
  logic                 ebreak_o;
  logic                 lsu_req_o;
  logic                 lsu_we_o;
  logic [`EXU_XLEN-1:0] lsu_addr_o;
  logic [`EXU_XLEN-1:0] lsu_wdata_o;
  logic                 lsu_rvalid_i;
  logic [`EXU_XLEN-1:0] lsu_rdata_i;
  logic                 lsu_wready_i;

  // reference copy of the machine CSRs
  logic [`EXU_XLEN-1:0] m_mstatus = '0;
  logic [`EXU_XLEN-1:0] m_mtvec = `EXU_MTVEC_RESET;
  logic [`EXU_XLEN-1:0] m_mepc = '0;
  logic [`EXU_XLEN-1:0] m_mcause = '0;
  logic [`EXU_XLEN-1:0] mem [16];
  logic [`EXU_XLEN-1:0] ref_mem [16];
  logic [31:0]          lfsr = 32'h1;
  logic [31:0]          mem_wait;
  bit                   mem_busy;
  op_t                  stim [$];
  op_t                  pending [$];
  int                   delivered = 0;
  int                   limit;
  int                   cycles;
  int                   idx;

  exu_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [`EXU_XLEN-1:0] fill_word(int i);
    return 32'hC3C3_0000 ^ (32'(i) << 2);
  endfunction

  function automatic logic signed_lt(logic [`EXU_XLEN-1:0] a, logic [`EXU_XLEN-1:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic [`EXU_XLEN-1:0] csr_read(logic [11:0] addr);
    case (addr)
      `EXU_CSR_MSTATUS:  return m_mstatus;
      `EXU_CSR_MTVEC:    return m_mtvec;
      `EXU_CSR_MEPC:     return m_mepc;
      `EXU_CSR_MCAUSE:   return m_mcause;
      `EXU_CSR_MINSTRET: return 32'(delivered);
      default:           return '0;
    endcase
  endfunction

  function automatic exp_t expect_result(op_t o);
    exp_t        e;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        taken;
    e = '0;
    a = o.op1;
    b = o.op2;
    sh = b[4:0];
    e.npc = o.pc + 32'd4;
    case (o.opcode)
      exu_pkg::OP_ALU: begin
        e.wen = 1'b1;
        case (o.alu_op)
          exu_pkg::ALU_ADD:  e.wdata = a + b;
          exu_pkg::ALU_SUB:  e.wdata = a + ~b + 32'd1;
          exu_pkg::ALU_AND:  e.wdata = a & b;
          exu_pkg::ALU_OR:   e.wdata = a | b;
          exu_pkg::ALU_XOR:  e.wdata = a ^ b;
          exu_pkg::ALU_SLL:  e.wdata = a << sh;
          exu_pkg::ALU_SRL:  e.wdata = a >> sh;
          // sign fill above the shifted bits
          exu_pkg::ALU_SRA:  e.wdata = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
          exu_pkg::ALU_SLT:  e.wdata = signed_lt(a, b) ? 32'd1 : 32'd0;
          default:           e.wdata = (a < b) ? 32'd1 : 32'd0;
        endcase
      end
      exu_pkg::OP_BRANCH: begin
        case (o.br_cond)
          exu_pkg::BR_EQ:  taken = a == b;
          exu_pkg::BR_NE:  taken = a != b;
          exu_pkg::BR_LT:  taken = signed_lt(a, b);
          exu_pkg::BR_GE:  taken = !signed_lt(a, b);
          exu_pkg::BR_LTU: taken = a < b;
          default:         taken = !(a < b);
        endcase
        e.redirect = taken;
        e.npc = taken ? o.pc + o.imm : e.npc;
      end
      exu_pkg::OP_JAL, exu_pkg::OP_JALR: begin
        e.wen = 1'b1;
        e.wdata = o.pc + 32'd4;
        e.redirect = 1'b1;
        e.npc = (o.opcode == exu_pkg::OP_JAL) ? o.pc + o.imm : ((a + o.imm) >> 1) << 1;
      end
      exu_pkg::OP_LOAD: begin
        e.wen = 1'b1;
        e.wdata = ref_mem[4'((a + o.imm) >> 2)];
      end
      exu_pkg::OP_SYSTEM: begin
        case (o.sys_op)
          exu_pkg::SYS_ECALL: begin
            e.redirect = 1'b1;
            e.npc = m_mtvec;
          end
          exu_pkg::SYS_MRET: begin
            e.redirect = 1'b1;
            e.npc = m_mepc;
          end
          exu_pkg::SYS_EBREAK: e.ebreak = 1'b1;
          default: begin
            e.wen = 1'b1;
            e.wdata = csr_read(o.csr_addr);
          end
        endcase
      end
      default: ;
    endcase
    return e;
  endfunction

  function automatic void update_model(op_t o);
    logic [`EXU_XLEN-1:0] nv;
    nv = o.op1;
    if (o.opcode == exu_pkg::OP_STORE) ref_mem[4'((o.op1 + o.imm) >> 2)] = o.op2;
    if (o.opcode != exu_pkg::OP_SYSTEM) return;
    if (o.sys_op == exu_pkg::SYS_CSRRS) nv = csr_read(o.csr_addr) | o.op1;
    if (o.sys_op == exu_pkg::SYS_CSRRC) nv = csr_read(o.csr_addr) & ~o.op1;
    case (o.sys_op)
      exu_pkg::SYS_ECALL: begin
        m_mepc = o.pc;
        m_mcause = `EXU_CAUSE_ECALL_M;
      end
      exu_pkg::SYS_MRET: m_mstatus[7] = 1'b1;
      exu_pkg::SYS_EBREAK: ;
      default: begin
        if (o.csr_addr == `EXU_CSR_MSTATUS) m_mstatus = nv;
        if (o.csr_addr == `EXU_CSR_MTVEC) m_mtvec = nv;
        if (o.csr_addr == `EXU_CSR_MEPC) m_mepc = nv;
        if (o.csr_addr == `EXU_CSR_MCAUSE) m_mcause = nv;
      end
    endcase
  endfunction

  task automatic report_failure(string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "exu_tb stopped at the first error");
  endtask

  task automatic check_word(string name, logic [`EXU_XLEN-1:0] got, logic [`EXU_XLEN-1:0] exp);
    if (got !== exp) report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_alu_op(exu_pkg::alu_op_e op, logic [`EXU_XLEN-1:0] got,
                              logic [`EXU_XLEN-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail reg_wdata_o (%s): got %h expected %h", op.name(), got, exp));
    end
  endtask

  function automatic op_t new_op(exu_pkg::opcode_e oc);
    op_t o;
    o = '0;
    o.opcode = oc;
    o.op1 = take_bits(32);
    o.op2 = take_bits(32);
    o.imm = take_bits(32);
    o.pc = take_bits(30) << 2;
    o.rd = 5'(take_bits(5));
    return o;
  endfunction

  task automatic add_system_op(exu_pkg::sys_op_e sop, logic [11:0] addr, logic [31:0] wsrc);
    op_t o;
    o = new_op(exu_pkg::OP_SYSTEM);
    o.sys_op = sop;
    o.csr_addr = addr;
    o.op1 = wsrc;
    stim.push_back(o);
  endtask

  task automatic build_stimulus();
    op_t        o;
    logic [3:0] slot [8];
    int         i;
    for (i = 0; i < 40; i++) begin
      o = new_op(exu_pkg::OP_ALU);
      o.alu_op = exu_pkg::alu_op_e'(4'(i % 10));
      stim.push_back(o);
    end
    for (i = 0; i < 24; i++) begin
      o = new_op(exu_pkg::OP_BRANCH);
      o.br_cond = exu_pkg::br_cond_e'(3'(i % 6));
      if (take_bits(1) == 32'd1) o.op2 = o.op1;
      stim.push_back(o);
    end
    for (i = 0; i < 4; i++) stim.push_back(new_op(i < 2 ? exu_pkg::OP_JAL : exu_pkg::OP_JALR));
    // word slots reached through op1 + imm
    for (i = 0; i < 16; i++) begin
      if (i < 8) slot[i] = 4'(take_bits(4));
      o = new_op(i < 8 ? exu_pkg::OP_STORE : exu_pkg::OP_LOAD);
      o.imm = (32'(slot[i % 8]) << 2) - o.op1;
      stim.push_back(o);
    end
    add_system_op(exu_pkg::SYS_CSRRW, `EXU_CSR_MTVEC, take_bits(32) & 32'hFFFF_FFFC);
    add_system_op(exu_pkg::SYS_CSRRS, `EXU_CSR_MTVEC, 32'h0000_00F0);
    add_system_op(exu_pkg::SYS_CSRRC, `EXU_CSR_MTVEC, 32'h0000_0030);
    add_system_op(exu_pkg::SYS_CSRRS, `EXU_CSR_MTVEC, 32'h0);
    add_system_op(exu_pkg::SYS_CSRRW, 12'h340, take_bits(32));
    add_system_op(exu_pkg::SYS_CSRRS, 12'h340, 32'h0);
    add_system_op(exu_pkg::SYS_ECALL, 12'h0, 32'h0);
    add_system_op(exu_pkg::SYS_CSRRS, `EXU_CSR_MEPC, 32'h0);
    add_system_op(exu_pkg::SYS_CSRRS, `EXU_CSR_MCAUSE, 32'h0);
    add_system_op(exu_pkg::SYS_MRET, 12'h0, 32'h0);
    add_system_op(exu_pkg::SYS_CSRRS, `EXU_CSR_MSTATUS, 32'h0);
    add_system_op(exu_pkg::SYS_EBREAK, 12'h0, 32'h0);
    add_system_op(exu_pkg::SYS_CSRRW, `EXU_CSR_MINSTRET, take_bits(32));
    add_system_op(exu_pkg::SYS_CSRRS, `EXU_CSR_MINSTRET, 32'h0);
  endtask

  task automatic drive_op(op_t o);
    opcode_i = o.opcode;
    alu_op_i = o.alu_op;
    br_cond_i = o.br_cond;
    sys_op_i = o.sys_op;
    csr_addr_i = o.csr_addr;
    op1_i = o.op1;
    op2_i = o.op2;
    imm_i = o.imm;
    pc_i = o.pc;
    rd_i = o.rd;
  endtask

  // one strobe per request after 0 to 3 idle cycles
  task automatic respond_memory();
    op_t o;
    lsu_rvalid_i = 1'b0;
    lsu_wready_i = 1'b0;
    if (lsu_req_o) begin
      if (pending.size() == 0) report_failure("A memory request came with no operation open");
      o = pending[0];
      if (o.opcode != exu_pkg::OP_LOAD && o.opcode != exu_pkg::OP_STORE) begin
        report_failure("A memory request came for an operation that is not a load or store");
      end
      // request fields must hold until the strobe
      check_bit("lsu_we_o", lsu_we_o, o.opcode == exu_pkg::OP_STORE);
      check_word("lsu_addr_o", lsu_addr_o, o.op1 + o.imm);
      if (o.opcode == exu_pkg::OP_STORE) check_word("lsu_wdata_o", lsu_wdata_o, o.op2);
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = take_bits(2);
      end
      if (mem_wait == 32'd0) begin
        mem_busy = 1'b0;
        if (lsu_we_o) mem[lsu_addr_o[5:2]] = lsu_wdata_o;
        lsu_rdata_i = mem[lsu_addr_o[5:2]];
        lsu_wready_i = lsu_we_o;
        lsu_rvalid_i = !lsu_we_o;
      end else begin
        mem_wait = mem_wait - 32'd1;
      end
    end
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) report_failure($sformatf("Timeout after %0d cycles", cycles));
    end
  end

  // compares every delivered result
  initial begin
    op_t  o;
    exp_t e;
    for (int i = 0; i < 16; i++) ref_mem[i] = fill_word(i);
    forever begin
      @(negedge clk);
      #2;
      if (!rst && valid_o && next_ready_i) begin
        if (pending.size() == 0) report_failure("A result was delivered with no operation open");
        o = pending.pop_front();
        e = expect_result(o);
        check_bit("rd_wen_o", rd_wen_o, e.wen);
        check_bit("redirect_o", redirect_o, e.redirect);
        check_bit("ebreak_o", ebreak_o, e.ebreak);
        check_word("npc_o", npc_o, e.npc);
        if (e.wen) check_word("rd_o", `EXU_XLEN'(rd_o), `EXU_XLEN'(o.rd));
        if (e.wen && o.opcode == exu_pkg::OP_ALU) check_alu_op(o.alu_op, reg_wdata_o, e.wdata);
        else if (e.wen) check_word("reg_wdata_o", reg_wdata_o, e.wdata);
        update_model(o);
        delivered++;
      end
    end
  end

  initial begin
    rst = 1'b1;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    lsu_rvalid_i = 1'b0;
    lsu_rdata_i = '0;
    lsu_wready_i = 1'b0;
    mem_busy = 1'b0;
    mem_wait = '0;
    idx = 0;
    drive_op('0);
    for (int i = 0; i < 16; i++) mem[i] = fill_word(i);
    build_stimulus();
    limit = stim.size() * 10;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("lsu_req_o", lsu_req_o, 1'b0);
    check_bit("redirect_o", redirect_o, 1'b0);
    check_bit("ebreak_o", ebreak_o, 1'b0);
    while (delivered < stim.size()) begin
      @(negedge clk);
      prev_valid_i = idx < stim.size();
      if (prev_valid_i) drive_op(stim[idx]);
      next_ready_i = take_bits(2) != 32'd0;
      respond_memory();
      #1;
      if (prev_valid_i && ready_o) begin
        pending.push_back(stim[idx]);
        idx++;
      end
    end
    // an extra delivery here would find no open operation
    @(negedge clk);
    prev_valid_i = 1'b0;
    next_ready_i = 1'b1;
    repeat (5) @(negedge clk);
    if (valid_o || lsu_req_o || !ready_o) begin
      report_failure("The unit did not return to idle after the last delivery");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire
